//--- compile.f
verilog/rom_check_pkg.sv
verilog/rom_mem.sv
verilog/rom_arbiter.sv
verilog/rom_digest.sv
verilog/rom_compare.sv
verilog/rom_check_top.sv
test/rom_check_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ROM checker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rom_check_tb \
  -f compile.f --Mdir obj_dir -o rom_check_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rom_check_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the testbench printed its pass line
if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- rom_image.hex
// One 32-bit hex word per line: 14 data words, then digest word 0 and word 1
00000011
00000202
00000473
00000624
000008D5
00000AC6
00000CB7
00000E68
00001199
0000138A
000015FB
000017AC
0000195D
00001B4E
000000EE
0000C2A0

//--- test/rom_check_tb.sv
/*
 * Testbench for the ROM integrity checker
 * Applies a table of host reads, check starts and output checks,
 * with expected values taken from the ROM image and a reference fold
 */
module rom_check_tb;
  import rom_check_pkg::*;

  // Longest wait for any single DUT event, in cycles
  localparam int unsigned wait_limit_lp = 100;

  typedef enum int {op_start, op_read, op_wait_done, op_wait_alert, op_check} op_e;

  logic        clk_i;
  logic        rst_ni;
  logic        start_i;
  logic        host_req_i;
  rom_addr_t   host_addr_i;
  logic        host_rvalid_o;
  rom_data_t   host_rdata_o;
  logic        done_o;
  mubi4_t      good_o;
  logic        alert_o;

  rom_data_t   image [rom_words_lp];
  digest_t     ref_digest;
  mubi4_t      good_exp;
  int unsigned edge_cnt = 0;
  int unsigned start_cnt = 0;
  logic        engine_busy = 1'b0;
  logic [31:0] rng_state;
  bit          table_ready = 1'b0;

  // Stimulus table, one entry per row in each queue
  op_e         row_op   [$];
  rom_addr_t   row_addr [$];
  logic [31:0] row_exp  [$];
  string       row_name [$];

  rom_check_top dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .done_o        (done_o),
    .good_o        (good_o),
    .alert_o       (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Rising edges seen so far, read only on falling edges
  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference digest over the data words of the image
  function automatic digest_t fold_image();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = '0;
    hi = '0;
    for (int i = 0; i < data_words_lp; i++) begin
      lo = ((lo << 5) | (lo >> 27)) ^ image[i];
      hi = hi + (image[i] ^ 32'(i));
    end
    return {hi, lo};
  endfunction

  // done, alert and good packed into one compare word
  function automatic logic [31:0] outputs_word(input logic done, input logic alert,
                                               input mubi4_t good);
    return {26'b0, done, alert, good};
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic add_row(input op_e op, input rom_addr_t addr, input logic [31:0] exp,
                         input string name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_exp.push_back(exp);
    row_name.push_back(name);
  endtask

  // Host read row, expected word straight from the image
  task automatic add_read(input rom_addr_t addr, input string name);
    add_row(op_read, addr, image[addr], name);
  endtask

  task automatic add_random_read(input string name);
    rng_state = xorshift32(rng_state);
    add_read(rom_addr_t'(rng_state[3:0]), name);
  endtask

  task automatic build_table();
    add_row(op_check, '0, outputs_word(1'b0, 1'b0, mubi4_false_lp), "reset_outputs");
    add_read(4'd0, "host_read_first");
    add_read(4'd7, "host_read_mid");
    add_read(rom_addr_t'(rom_words_lp - 1), "host_read_digest");
    for (int i = 0; i < 3; i++) begin
      add_random_read("host_read_rand");
    end
    // Host read issued right behind start lands in the engine burst
    add_row(op_start, '0, '0, "start_check");
    add_random_read("host_read_busy");
    add_row(op_wait_done, '0, 32'd21, "done_latency");
    add_row(op_check, '0, outputs_word(1'b1, 1'b0, good_exp), "result_outputs");
    add_random_read("host_read_after");
    // Restart after done, comparator start arrives outside Waiting
    add_row(op_start, '0, '0, "second_start");
    add_row(op_wait_alert, '0, '0, "alert_rise");
    add_row(op_check, '0, outputs_word(1'b1, 1'b1, good_exp), "alert_outputs");
    add_random_read("host_read_late");
    add_random_read("host_read_late");
    add_row(op_check, '0, outputs_word(1'b1, 1'b1, good_exp), "alert_sticky");
  endtask

  task automatic pulse_start();
    start_i     = 1'b1;
    start_cnt   = edge_cnt;
    engine_busy = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  task automatic host_read(input rom_addr_t addr, input logic [31:0] exp,
                           input string name);
    int unsigned n;
    host_req_i  = 1'b1;
    host_addr_i = addr;
    @(negedge clk_i);
    host_req_i = 1'b0;
    n = 0;
    while (!host_rvalid_o) begin
      if (n == wait_limit_lp) begin
        stop_with_failure({name, ": host read never returned rvalid"});
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
    check_value({name, "_data"}, exp, host_rdata_o);
    // Host waits out all 16 engine reads, granted on the edge after the last
    if (engine_busy) begin
      check_value({name, "_delay"}, start_cnt + rom_words_lp + 2, edge_cnt);
    end
    @(negedge clk_i);
    check_value({name, "_pulse"}, 32'd0, host_rvalid_o);
  endtask

  task automatic wait_for(input bit on_alert, input string what);
    int unsigned n;
    n = 0;
    while (!(on_alert ? alert_o : done_o)) begin
      if (n == wait_limit_lp) begin
        stop_with_failure({what, " did not rise within the wait limit"});
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
    engine_busy = 1'b0;
  endtask

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    repeat (row_op.size() * 40 + 100) @(posedge clk_i);
    stop_with_failure("Watchdog expired before the stimulus table finished");
  end

  initial begin
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    host_req_i  = 1'b0;
    host_addr_i = '0;
    rng_state   = 32'd42;
    $readmemh(rom_image_lp, image);
    ref_digest = fold_image();
    // Stored words sit above the data, word 0 lowest
    if (ref_digest == {image[rom_words_lp - 1], image[data_words_lp]}) begin
      good_exp = mubi4_true_lp;
    end else begin
      good_exp = mubi4_false_lp;
    end
    build_table();
    table_ready = 1'b1;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int r = 0; r < row_op.size(); r++) begin
      case (row_op[r])
        op_start: pulse_start();
        op_read: host_read(row_addr[r], row_exp[r], row_name[r]);
        op_wait_done: begin
          wait_for(1'b0, "done_o");
          check_value(row_name[r], row_exp[r], edge_cnt - start_cnt);
        end
        op_wait_alert: wait_for(1'b1, "alert_o");
        default: begin
          check_value(row_name[r], row_exp[r], outputs_word(done_o, alert_o, good_o));
        end
      endcase
    end
    $display("TEST OK");
    $finish;
  end

endmodule

//--- verilog/rom_check_top.sv
/*
 * ROM integrity checker top
 * ROM shared by the digest engine and a host read port through a
 * fixed-priority arbiter, digest result judged by the comparator
 */
module rom_check_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  logic                     host_req_i,
  input  rom_check_pkg::rom_addr_t host_addr_i,
  output logic                     host_rvalid_o,
  output rom_check_pkg::rom_data_t host_rdata_o,
  output logic                     done_o,
  output rom_check_pkg::mubi4_t    good_o,
  output logic                     alert_o
);
  import rom_check_pkg::*;

  rom_req_t  eng_req;
  rom_rsp_t  eng_rsp;
  rom_rsp_t  host_rsp;
  rom_req_t  mem_req;
  rom_data_t mem_rdata;
  logic      cmp_start;
  digest_t   digest;
  digest_t   exp_digest;

  rom_mem u_mem (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .rdata_o (mem_rdata)
  );

  // Engine has priority over the host
  rom_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .eng_req_i   (eng_req),
    .eng_rsp_o   (eng_rsp),
    .host_req_i  (host_req_i),
    .host_addr_i (host_addr_i),
    .host_rsp_o  (host_rsp),
    .mem_req_o   (mem_req),
    .mem_rdata_i (mem_rdata)
  );

  rom_digest u_digest (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .req_o        (eng_req),
    .rsp_i        (eng_rsp),
    .cmp_start_o  (cmp_start),
    .digest_o     (digest),
    .exp_digest_o (exp_digest)
  );

  rom_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (cmp_start),
    .done_o       (done_o),
    .good_o       (good_o),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .alert_o      (alert_o)
  );

  // Host response split onto plain ports
  assign host_rvalid_o = host_rsp.rvalid;
  assign host_rdata_o  = host_rsp.rdata;

endmodule

//--- verilog/rom_compare.sv
/*
 * Digest comparator
 * Walks the two digests one 32-bit word per cycle, then holds done
 * and a multi-bit good value. Any control-flow or counter
 * inconsistency raises a sticky alert
 */
module rom_compare (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  output logic                   done_o,
  output rom_check_pkg::mubi4_t  good_o,
  input  rom_check_pkg::digest_t digest_i,
  input  rom_check_pkg::digest_t exp_digest_i,
  output logic                   alert_o
);
  import rom_check_pkg::*;

  cmp_state_e state_q;
  cmp_state_e state_d;
  word_idx_t  idx_q;
  logic       last_word;
  logic       idx_incr;
  logic       match_q;
  logic       match_next;
  rom_data_t  dig_word;
  rom_data_t  exp_word;
  mubi4_t     good_q;
  logic       alert_q;
  logic       fsm_alert;
  logic       start_alert;
  logic       wait_idx_alert;
  logic       done_idx_alert;

  assign last_word = (idx_q == word_idx_t'(digest_words_lp - 1));

  // Next state
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      cmp_waiting: begin
        if (start_i) begin
          state_d = cmp_checking;
        end
      end
      cmp_checking: begin
        // One word per cycle
        if (last_word) begin
          state_d = cmp_done;
        end
      end
      cmp_done: begin
        // Terminal until reset
        state_d = cmp_done;
      end
      default: begin
        fsm_alert = 1'b1;
      end
    endcase
  end

  // Current word pair
  assign dig_word = digest_i[32*idx_q +: 32];
  assign exp_word = exp_digest_i[32*idx_q +: 32];

  assign idx_incr   = (state_q == cmp_checking) && !last_word;
  assign match_next = (state_q == cmp_checking) ? (match_q && (dig_word == exp_word))
                                                : match_q;

  // Consistency checks
  assign start_alert    = start_i && (state_q != cmp_waiting);
  assign wait_idx_alert = (state_q == cmp_waiting) && (idx_q != '0);
  assign done_idx_alert = (state_q == cmp_done) && !last_word;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cmp_waiting;
      idx_q   <= '0;
      match_q <= 1'b1;
      good_q  <= mubi4_false_lp;
      alert_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (idx_incr) begin
        idx_q <= idx_q + 1'b1;
      end
      match_q <= match_next;
      // Good lands together with done
      good_q  <= ((state_d == cmp_done) && match_next) ? mubi4_true_lp : mubi4_false_lp;
      // Sticky until reset
      alert_q <= alert_q | fsm_alert | start_alert | wait_idx_alert | done_idx_alert;
    end
  end

  assign done_o  = (state_q == cmp_done);
  assign good_o  = good_q;
  assign alert_o = alert_q;

endmodule

//--- verilog/rom_digest.sv
/*
 * ROM digest engine
 * On start, reads all 16 ROM words on back-to-back cycles, folds the
 * 14 data words into a 64-bit digest with a rotate/xor/add rule and
 * captures the 2 stored words as the expected digest. Pulses the
 * comparator start one cycle after the last response
 */
module rom_digest (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  output rom_check_pkg::rom_req_t req_o,
  input  rom_check_pkg::rom_rsp_t rsp_i,
  output logic                    cmp_start_o,
  output rom_check_pkg::digest_t  digest_o,
  output rom_check_pkg::digest_t  exp_digest_o
);
  import rom_check_pkg::*;

  logic      busy_q;
  logic      req_active_q;
  rom_addr_t req_addr_q;
  rom_addr_t rsp_cnt_q;
  digest_t   digest_q;
  digest_t   exp_q;
  logic      cmp_start_q;
  logic      launch;
  logic      last_req;
  logic      last_rsp;
  logic      data_rsp;
  rom_data_t fold_lo;
  rom_data_t fold_hi;
  word_idx_t exp_idx;

  // Start ignored while a pass is running
  assign launch   = start_i && !busy_q;
  assign last_req = (req_addr_q == rom_addr_t'(rom_words_lp - 1));
  assign last_rsp = rsp_i.rvalid && (rsp_cnt_q == rom_addr_t'(rom_words_lp - 1));

  // Responses below the digest area are data words
  assign data_rsp = (rsp_cnt_q < rom_addr_t'(data_words_lp));
  // Digest word slot for addresses 14 and 15
  assign exp_idx  = word_idx_t'(rsp_cnt_q - rom_addr_t'(data_words_lp));

  // Low half rotl 5 then xor, high half adds word xor index
  assign fold_lo = {digest_q[26:0], digest_q[31:27]} ^ rsp_i.rdata;
  assign fold_hi = digest_q[63:32] + (rsp_i.rdata ^ rom_data_t'(rsp_cnt_q));

  // Request and response counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      req_active_q <= 1'b0;
      req_addr_q   <= '0;
      rsp_cnt_q    <= '0;
      cmp_start_q  <= 1'b0;
    end else begin
      cmp_start_q <= last_rsp;
      if (launch) begin
        busy_q       <= 1'b1;
        req_active_q <= 1'b1;
        req_addr_q   <= '0;
        rsp_cnt_q    <= '0;
      end else begin
        // Address wraps back to 0 after the last word
        if (req_active_q) begin
          req_addr_q <= req_addr_q + 1'b1;
          if (last_req) begin
            req_active_q <= 1'b0;
          end
        end
        if (rsp_i.rvalid) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
        if (last_rsp) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Running digest, cleared for every pass
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (launch) begin
      digest_q <= '0;
    end else if (rsp_i.rvalid && data_rsp) begin
      digest_q <= {fold_hi, fold_lo};
    end
  end

  // Stored digest words
  always_ff @(posedge clk_i) begin
    if (rsp_i.rvalid && !data_rsp) begin
      exp_q[32*exp_idx +: 32] <= rsp_i.rdata;
    end
  end

  assign req_o        = '{req: req_active_q, addr: req_addr_q};
  assign cmp_start_o  = cmp_start_q;
  assign digest_o     = digest_q;
  assign exp_digest_o = exp_q;

endmodule

//--- verilog/rom_arbiter.sv
/*
 * ROM port arbiter
 * Fixed priority between the digest engine and the host read port.
 * The engine always wins, a blocked host request waits in a one-deep
 * pending slot and read data returns to the peer that owned the
 * request issued one cycle earlier
 */
module rom_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rom_check_pkg::rom_req_t  eng_req_i,
  output rom_check_pkg::rom_rsp_t  eng_rsp_o,
  input  logic                     host_req_i,
  input  rom_check_pkg::rom_addr_t host_addr_i,
  output rom_check_pkg::rom_rsp_t  host_rsp_o,
  output rom_check_pkg::rom_req_t  mem_req_o,
  input  rom_check_pkg::rom_data_t mem_rdata_i
);
  import rom_check_pkg::*;

  logic      pend_q;
  rom_addr_t pend_addr_q;
  logic      host_grant;
  logic      rsp_valid_q;
  logic      rsp_host_q;

  // Host gets the port only in a cycle with no engine request
  assign host_grant = !eng_req_i.req && (pend_q || host_req_i);

  // Engine first, then the pending host read, then a fresh host read
  always_comb begin
    if (eng_req_i.req) begin
      mem_req_o = eng_req_i;
    end else if (pend_q) begin
      mem_req_o = '{req: 1'b1, addr: pend_addr_q};
    end else begin
      mem_req_o = '{req: host_req_i, addr: host_addr_i};
    end
  end

  // Pending slot and owner of the read in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_host_q  <= 1'b0;
    end else begin
      if (host_req_i && eng_req_i.req) begin
        pend_q <= 1'b1;
      end else if (host_grant) begin
        pend_q <= 1'b0;
      end
      rsp_valid_q <= mem_req_o.req;
      rsp_host_q  <= host_grant;
    end
  end

  // Address of a blocked host read
  always_ff @(posedge clk_i) begin
    if (host_req_i && eng_req_i.req) begin
      pend_addr_q <= host_addr_i;
    end
  end

  // Data goes to both, only the owner sees rvalid
  assign eng_rsp_o  = '{rvalid: rsp_valid_q && !rsp_host_q, rdata: mem_rdata_i};
  assign host_rsp_o = '{rvalid: rsp_host_q, rdata: mem_rdata_i};

endmodule

//--- verilog/rom_mem.sv
/*
 * Boot ROM array
 * 16 words preloaded from the image file, one registered read port
 * with data one cycle after the request strobe
 */
module rom_mem (
  input  logic                    clk_i,
  input  rom_check_pkg::rom_req_t req_i,
  output rom_check_pkg::rom_data_t rdata_o
);
  import rom_check_pkg::*;

  // ROM contents
  rom_data_t mem [rom_words_lp];

  // Fixed image, never written at runtime
  initial begin
    $readmemh(rom_image_lp, mem);
  end

  // Registered read, output holds between requests
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_o <= mem[req_i.addr];
    end
  end

endmodule

//--- verilog/rom_check_pkg.sv
/*
 * ROM integrity checker shared definitions
 * Widths, word types, ROM port structs and the multi-bit boolean
 * encoding used for the good flag
 */
package rom_check_pkg;

  // ROM geometry, expected digest sits in the top words
  localparam int unsigned rom_words_lp    = 16;
  localparam int unsigned digest_words_lp = 2;
  localparam int unsigned data_words_lp   = rom_words_lp - digest_words_lp;

  // Image loaded into the ROM at elaboration
  localparam string rom_image_lp = "rom_image.hex";

  typedef logic [3:0]  rom_addr_t;
  typedef logic [31:0] rom_data_t;
  // Word 0 in the low half
  typedef logic [63:0] digest_t;
  typedef logic        word_idx_t;

  // Read request, strobe plus word address
  typedef struct packed {
    logic      req;
    rom_addr_t addr;
  } rom_req_t;

  // Read response, one-cycle valid with its data
  typedef struct packed {
    logic      rvalid;
    rom_data_t rdata;
  } rom_rsp_t;

  // Multi-bit boolean, anything else counts as invalid
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t mubi4_true_lp  = 4'h6;
  localparam mubi4_t mubi4_false_lp = 4'h9;

  // Comparator FSM, encoding 2'b11 is unused and flagged
  typedef enum logic [1:0] {
    cmp_waiting  = 2'b00,
    cmp_checking = 2'b01,
    cmp_done     = 2'b10
  } cmp_state_e;

endpackage
